//--- hdl/game_sound_pkg.sv
`default_nettype none

package game_sound_pkg;

    // half a tone period in clock cycles, 0 is silence
    typedef logic [14:0] half_period_t;

    // beat ticks within a step or an effect
    typedef logic [4:0] tick_count_t;

    // melody step index
    typedef logic [4:0] step_t;

    // clock cycles inside the beat prescaler
    typedef logic [15:0] beat_count_t;

    // note pitches as half periods
    localparam half_period_t HALF_G     = 15'd15250;
    localparam half_period_t HALF_B     = 15'd24125;
    localparam half_period_t HALF_D     = 15'd20500;
    localparam half_period_t HALF_E     = 15'd18250;
    localparam half_period_t HALF_C     = 15'd23000;
    localparam half_period_t HALF_BFLAT = 15'd26000;

    // notes of the even steps, odd steps are rests
    localparam half_period_t MELODY [16] = '{
        HALF_G, HALF_B, HALF_D, HALF_B,
        HALF_G, HALF_B, HALF_E, HALF_B,
        HALF_D, HALF_B, HALF_D, HALF_B,
        HALF_D, HALF_B, HALF_C, HALF_B
    };

    // step and effect lengths in beat ticks
    localparam tick_count_t NOTE_TICKS   = 5'd25;
    localparam tick_count_t REST_TICKS   = 5'd30;
    localparam tick_count_t EFFECT_TICKS = 5'd31;

    localparam int MELODY_STEPS = 32;

    // collision effect pitches
    localparam half_period_t GOOD_HALF = HALF_C;
    localparam half_period_t BAD_HALF  = HALF_BFLAT;

    // enabled clock cycles per beat tick
    localparam beat_count_t TICK_CYCLES_DEFAULT = 16'd50000;

endpackage

`default_nettype wire

//--- hdl/beat_prescaler.sv
`default_nettype none

module beat_prescaler #(
    parameter game_sound_pkg::beat_count_t tick_cycles = game_sound_pkg::TICK_CYCLES_DEFAULT
) (
    input  logic clk,
    input  logic nrst,
    input  logic enable_i,
    output logic tick_o
);

    game_sound_pkg::beat_count_t count;

    // count only enabled cycles, hold otherwise
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count  <= '0;
            tick_o <= 1'b0;
        end else if (enable_i) begin
            if (count == tick_cycles - 1'b1) begin
                count  <= '0;
                tick_o <= 1'b1;
            end else begin
                count  <= count + 1'b1;
                tick_o <= 1'b0;
            end
        end else begin
            tick_o <= 1'b0;
        end
    end

    // a tick is a single-cycle pulse unless every cycle is a tick
    assert property (@(posedge clk) disable iff (!nrst)
        (tick_cycles > 1) && tick_o |=> !tick_o);

endmodule

`default_nettype wire

//--- hdl/melody_sequencer.sv
`default_nettype none

module melody_sequencer (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         tick_i,
    output game_sound_pkg::half_period_t melody_half_o
);

    game_sound_pkg::step_t       step;
    game_sound_pkg::step_t       next_step;
    game_sound_pkg::tick_count_t tick_cnt;
    game_sound_pkg::tick_count_t step_len;
    game_sound_pkg::half_period_t next_half;
    logic                        step_done;

    // odd steps are rests and last longer
    always_comb begin
        if (step[0]) begin
            step_len = game_sound_pkg::REST_TICKS;
        end else begin
            step_len = game_sound_pkg::NOTE_TICKS;
        end
    end

    assign step_done = tick_i && (tick_cnt == step_len - 1'b1);

    // 5-bit step wraps from 31 back to 0
    assign next_step = step + 1'b1;

    // pitch of the step about to start
    always_comb begin
        if (next_step[0]) begin
            next_half = '0;
        end else begin
            next_half = game_sound_pkg::MELODY[next_step[4:1]];
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            step          <= '0;
            tick_cnt      <= '0;
            melody_half_o <= game_sound_pkg::MELODY[0];
        end else if (step_done) begin
            step          <= next_step;
            tick_cnt      <= '0;
            melody_half_o <= next_half;
        end else if (tick_i) begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!nrst)
        step[0] |-> (melody_half_o == '0));

endmodule

`default_nettype wire

//--- hdl/effect_player.sv
`default_nettype none

module effect_player (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         tick_i,
    input  logic                         good_collision_i,
    input  logic                         bad_collision_i,
    output logic                         effect_active_o,
    output game_sound_pkg::half_period_t effect_half_o
);

    typedef enum logic [1:0] {
        EFFECT_IDLE,
        EFFECT_GOOD,
        EFFECT_BAD
    } effect_state_t;

    effect_state_t               state;
    game_sound_pkg::tick_count_t tick_cnt;

    // a new collision restarts the effect, good wins over bad
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state           <= EFFECT_IDLE;
            tick_cnt        <= '0;
            effect_active_o <= 1'b0;
        end else if (good_collision_i) begin
            state           <= EFFECT_GOOD;
            tick_cnt        <= '0;
            effect_active_o <= 1'b1;
        end else if (bad_collision_i) begin
            state           <= EFFECT_BAD;
            tick_cnt        <= '0;
            effect_active_o <= 1'b1;
        end else if (state != EFFECT_IDLE && tick_i) begin
            if (tick_cnt == game_sound_pkg::EFFECT_TICKS - 1'b1) begin
                state           <= EFFECT_IDLE;
                tick_cnt        <= '0;
                effect_active_o <= 1'b0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        case (state)
            EFFECT_GOOD: effect_half_o = game_sound_pkg::GOOD_HALF;
            EFFECT_BAD:  effect_half_o = game_sound_pkg::BAD_HALF;
            default:     effect_half_o = '0;
        endcase
    end

    // active flag kept in step with the state register
    assert property (@(posedge clk) disable iff (!nrst)
        effect_active_o == (state != EFFECT_IDLE));

endmodule

`default_nettype wire

//--- hdl/tone_generator.sv
`default_nettype none

module tone_generator (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         enable_i,
    input  logic                         effect_active_i,
    input  game_sound_pkg::half_period_t melody_half_i,
    input  game_sound_pkg::half_period_t effect_half_i,
    output logic                         sound_o
);

    game_sound_pkg::half_period_t sel_half;
    game_sound_pkg::half_period_t prev_half;
    game_sound_pkg::half_period_t count;
    logic                         silent;
    logic                         changed;

    // effect has priority over the melody
    assign sel_half = effect_active_i ? effect_half_i : melody_half_i;
    assign silent   = !enable_i || (sel_half == '0);
    assign changed  = (sel_half != prev_half);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            prev_half <= '0;
        end else begin
            prev_half <= sel_half;
        end
    end

    // 50 % square wave, restarted low on silence or a new pitch
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count   <= '0;
            sound_o <= 1'b0;
        end else if (silent || changed) begin
            count   <= '0;
            sound_o <= 1'b0;
        end else if (count == sel_half - 1'b1) begin
            count   <= '0;
            sound_o <= !sound_o;
        end else begin
            count <= count + 1'b1;
        end
    end

    // output settles low one edge after enable drops
    assert property (@(posedge clk) disable iff (!nrst)
        !enable_i |=> !sound_o);

endmodule

`default_nettype wire

//--- hdl/game_sound_top.sv
`default_nettype none

module game_sound_top #(
    parameter game_sound_pkg::beat_count_t tick_cycles = game_sound_pkg::TICK_CYCLES_DEFAULT
) (
    input  logic clk,
    input  logic nrst,
    input  logic enable_i,
    input  logic good_collision_i,
    input  logic bad_collision_i,
    output logic sound_o
);

    logic                         tick;
    logic                         effect_active;
    game_sound_pkg::half_period_t melody_half;
    game_sound_pkg::half_period_t effect_half;

    beat_prescaler #(
        .tick_cycles(tick_cycles)
    ) beat_prescaler_i (
        .clk     (clk),
        .nrst    (nrst),
        .enable_i(enable_i),
        .tick_o  (tick)
    );

    melody_sequencer melody_sequencer_i (
        .clk          (clk),
        .nrst         (nrst),
        .tick_i       (tick),
        .melody_half_o(melody_half)
    );

    // runs beside the melody so the tune keeps its place
    effect_player effect_player_i (
        .clk             (clk),
        .nrst            (nrst),
        .tick_i          (tick),
        .good_collision_i(good_collision_i),
        .bad_collision_i (bad_collision_i),
        .effect_active_o (effect_active),
        .effect_half_o   (effect_half)
    );

    tone_generator tone_generator_i (
        .clk            (clk),
        .nrst           (nrst),
        .enable_i       (enable_i),
        .effect_active_i(effect_active),
        .melody_half_i  (melody_half),
        .effect_half_i  (effect_half),
        .sound_o        (sound_o)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic nrst
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = !clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/tb_game_sound.sv
`default_nettype none

module tb_game_sound;

    timeunit 1ns;
    timeprecision 1ps;

    localparam longint TICK        = 2000;
    localparam longint PAIR_TICKS  = longint'(game_sound_pkg::NOTE_TICKS)
                                   + longint'(game_sound_pkg::REST_TICKS);
    localparam longint MARGIN      = 300;
    localparam int     PHASE_LIMIT = 30000;
    localparam longint WAIT_LIMIT  = 1200000;
    localparam longint PAUSE_TICKS = 9;
    localparam longint PAUSE_HOLD  = 60000;

    logic clk;
    logic nrst;
    logic enable;
    logic good_collision;
    logic bad_collision;
    logic sound;

    longint      enabled_cycles;
    logic [31:0] lcg_state = 32'h848ad66a;

    tb_clock_gen clock_gen_i (
        .clk (clk),
        .nrst(nrst)
    );

    game_sound_top #(
        .tick_cycles(game_sound_pkg::beat_count_t'(TICK))
    ) dut_i (
        .clk             (clk),
        .nrst            (nrst),
        .enable_i        (enable),
        .good_collision_i(good_collision),
        .bad_collision_i (bad_collision),
        .sound_o         (sound)
    );

    // model time base, the prescaler sees the same enabled edges
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            enabled_cycles <= 0;
        end else if (enable) begin
            enabled_cycles <= enabled_cycles + 1;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // absolute step index from the number of ticks since enable
    function automatic longint abs_step(input longint ticks);
        longint pair;
        longint rem;
        pair = ticks / PAIR_TICKS;
        rem  = ticks % PAIR_TICKS;
        return 2 * pair + ((rem >= game_sound_pkg::NOTE_TICKS) ? 1 : 0);
    endfunction

    function automatic longint step_start(input longint n);
        return (n / 2) * PAIR_TICKS + (n % 2) * longint'(game_sound_pkg::NOTE_TICKS);
    endfunction

    function automatic game_sound_pkg::half_period_t expected_half(input longint n);
        if (n % 2) begin
            return '0;
        end
        return game_sound_pkg::MELODY[(n % game_sound_pkg::MELODY_STEPS) / 2];
    endfunction

    task automatic fail_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
        fail_run();
    endtask

    task automatic check_half(input game_sound_pkg::half_period_t actual,
                              input game_sound_pkg::half_period_t expected,
                              input string what);
        if (actual !== expected) begin
            $display("Error at %0t: %s width is %0d, expected %0d",
                     $time, what, actual, expected);
            fail_run();
        end
    endtask

    task automatic check_level(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("Error at %0t: sound_o is %b, expected %b (%s)",
                     $time, actual, expected, what);
            fail_run();
        end
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        while (nrst !== 1'b1) begin
            if (waited == 100) begin
                fail_timeout("reset release");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic wait_enabled(input longint target);
        longint waited;
        waited = 0;
        while (enabled_cycles < target) begin
            if (waited == WAIT_LIMIT) begin
                fail_timeout("the melody position to advance");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic check_silent(input longint cycles, input string what);
        for (longint i = 0; i < cycles; i++) begin
            check_level(sound, 1'b0, what);
            @(negedge clk);
        end
    endtask

    // next complete high phase, then optionally the low phase after it
    task automatic measure_phases(input bit with_low,
                                  output game_sound_pkg::half_period_t high_w,
                                  output game_sound_pkg::half_period_t low_w);
        int waited;
        int width;
        high_w = '0;
        low_w  = '0;
        waited = 0;
        @(negedge clk);
        while (sound !== 1'b0) begin
            if (waited == PHASE_LIMIT) begin
                fail_timeout("sound_o to go low before a high phase");
            end
            waited++;
            @(negedge clk);
        end
        waited = 0;
        while (sound !== 1'b1) begin
            if (waited == PHASE_LIMIT) begin
                fail_timeout("a rising edge of sound_o");
            end
            waited++;
            @(negedge clk);
        end
        width = 0;
        while (sound === 1'b1) begin
            if (width == PHASE_LIMIT) begin
                fail_timeout("the end of a high phase");
            end
            width++;
            @(negedge clk);
        end
        high_w = game_sound_pkg::half_period_t'(width);
        if (with_low) begin
            width = 0;
            while (sound === 1'b0) begin
                if (width == PHASE_LIMIT) begin
                    fail_timeout("the end of a low phase");
                end
                width++;
                @(negedge clk);
            end
            low_w = game_sound_pkg::half_period_t'(width);
        end
    endtask

    // notes are measured from just before they start, rests must stay low
    task automatic play_step(input longint n, input bit with_low);
        game_sound_pkg::half_period_t high_w;
        game_sound_pkg::half_period_t low_w;
        game_sound_pkg::half_period_t exp_half;
        exp_half = expected_half(n);
        if (exp_half == '0) begin
            wait_enabled(step_start(n) * TICK + MARGIN);
            check_silent(step_start(n + 1) * TICK - MARGIN - enabled_cycles, "rest step");
        end else begin
            wait_enabled(step_start(n) * TICK - MARGIN);
            measure_phases(with_low, high_w, low_w);
            check_half(high_w, exp_half, "melody high phase");
            if (with_low) begin
                check_half(low_w, exp_half, "melody low phase");
            end
        end
    endtask

    task automatic reset_disable_test();
        $display("test: reset and disable");
        wait_reset();
        check_silent(PAUSE_HOLD, "disabled after reset");
    endtask

    task automatic first_note_test();
        $display("test: first note and rest");
        enable = 1'b1;
        play_step(0, 1'b1);
        play_step(1, 1'b0);
    endtask

    task automatic melody_order_test();
        $display("test: melody order");
        for (longint n = 2; n < 8; n++) begin
            play_step(n, 1'b0);
        end
    endtask

    task automatic collision_test(input logic good, input logic bad,
                                  input game_sound_pkg::half_period_t exp_half,
                                  input string what);
        longint hit_cycle;
        longint end_cycle;
        longint n;
        game_sound_pkg::half_period_t high_w;
        game_sound_pkg::half_period_t low_w;
        $display("test: %s", what);
        hit_cycle = enabled_cycles + 1000 + longint'(lcg_next() % 32'd20000);
        wait_enabled(hit_cycle);
        good_collision = good;
        bad_collision  = bad;
        @(negedge clk);
        good_collision = 1'b0;
        bad_collision  = 1'b0;
        measure_phases(1'b0, high_w, low_w);
        check_half(high_w, exp_half, what);
        // effect ends on the last of its ticks after the hit
        end_cycle = (hit_cycle / TICK + longint'(game_sound_pkg::EFFECT_TICKS)) * TICK;
        wait_enabled(end_cycle + MARGIN);
        n = abs_step(enabled_cycles / TICK);
        if (n % 2) begin
            check_silent(step_start(n + 1) * TICK - MARGIN - enabled_cycles, "rest after effect");
            play_step(n + 1, 1'b0);
        end else begin
            if (step_start(n + 1) * TICK - enabled_cycles > 2 * expected_half(n) + 1000) begin
                measure_phases(1'b0, high_w, low_w);
                check_half(high_w, expected_half(n), "note after effect");
            end
            play_step(n + 1, 1'b0);
            play_step(n + 2, 1'b0);
        end
    endtask

    // G has a third edge that would fall in the rest if the tick count were lost
    task automatic enable_pause_test();
        longint m;
        game_sound_pkg::half_period_t high_w;
        game_sound_pkg::half_period_t low_w;
        $display("test: enable pause");
        m = abs_step(enabled_cycles / TICK) + 1;
        while (expected_half(m) != game_sound_pkg::HALF_G) begin
            m++;
        end
        wait_enabled((step_start(m) + PAUSE_TICKS) * TICK + 500);
        enable = 1'b0;
        @(negedge clk);
        check_silent(PAUSE_HOLD, "enable low during a note");
        enable = 1'b1;
        measure_phases(1'b0, high_w, low_w);
        check_half(high_w, game_sound_pkg::HALF_G, "resumed note");
        play_step(m + 1, 1'b0);
    endtask

    initial begin
        enable         = 1'b0;
        good_collision = 1'b0;
        bad_collision  = 1'b0;
        @(negedge clk);
        reset_disable_test();
        first_note_test();
        melody_order_test();
        collision_test(1'b1, 1'b0, game_sound_pkg::GOOD_HALF, "good collision");
        collision_test(1'b0, 1'b1, game_sound_pkg::BAD_HALF, "bad collision");
        collision_test(1'b1, 1'b1, game_sound_pkg::GOOD_HALF, "good and bad together");
        enable_pause_test();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hdl/game_sound_pkg.sv
hdl/beat_prescaler.sv
hdl/melody_sequencer.sv
hdl/effect_player.sv
hdl/tone_generator.sv
hdl/game_sound_top.sv
testbench/tb_clock_gen.sv
testbench/tb_game_sound.sv

//--- Bender.yml
package:
  name: game_sound

sources:
  - files:
      - hdl/game_sound_pkg.sv
      - hdl/beat_prescaler.sv
      - hdl/melody_sequencer.sv
      - hdl/effect_player.sv
      - hdl/tone_generator.sv
      - hdl/game_sound_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_game_sound.sv
